//--- include/decim_regs_defs.svh
`ifndef DECIM_REGS_DEFS_SVH
`define DECIM_REGS_DEFS_SVH

// ==================================================
// Coefficient bank geometry
// ==================================================

`define DECIM_FIR_TAPS   16       // FIR taps held in the bank
`define DECIM_HB_TAPS    9        // Halfband taps, odd length

`define DECIM_COEFF_W    18       // Stored coefficient width

// ==================================================
// Address map
// ==================================================

`define DECIM_FIR_BASE   8'd0     // FIR taps at 0..15
`define DECIM_HB_BASE    8'd64    // Halfband taps at 64..72

// ==================================================
// Pass-through defaults
// ==================================================

// Centre tap of each bank gets unity, all others zero
`define DECIM_FIR_CENTER 8
`define DECIM_HB_CENTER  4

`define DECIM_UNITY      18'h1_0000  // 1.0 with 16 fraction bits

`endif

//--- hdl/decim_regs_pkg.sv
`default_nettype none

`include "decim_regs_defs.svh"

package decim_regs_pkg;

    // One flag per filter stage
    typedef struct packed {
        logic cic;
        logic fir;
        logic hb;
    } stage_flags_t;

    // Raw configuration write as seen on the port
    typedef struct packed {
        logic [7:0]  addr;
        logic [31:0] data;
    } cfg_req_t;

    typedef enum logic {
        bank_fir = 1'b0,
        bank_hb  = 1'b1
    } bank_sel_e;

    typedef logic [`DECIM_COEFF_W-1:0] coeff_t;

    // Decoded write towards the coefficient bank
    typedef struct packed {
        logic      en;
        bank_sel_e bank;
        logic [4:0] tap;   // Index within the selected bank
        coeff_t    value;
    } coeff_wr_t;

    typedef struct packed {
        logic addr_err;
        logic range_err;
    } cfg_err_t;

    // Codes kept compatible with the existing firmware
    typedef enum logic [2:0] {
        err_none         = 3'd0,
        err_overflow     = 3'd1,
        err_underflow    = 3'd2,
        err_invalid_addr = 3'd4,
        err_coeff_range  = 3'd5
    } err_type_e;

    typedef struct packed {
        logic cic_active;   // bit 7
        logic fir_active;
        logic hb_active;
        logic error;
        logic overflow;
        logic underflow;
        logic addr_error;
        logic range_error;  // bit 0
    } status_t;

endpackage

`default_nettype wire

//--- hdl/cfg_write_decoder.sv
`default_nettype none

`include "decim_regs_defs.svh"

module cfg_write_decoder
    import decim_regs_pkg::*;
(
    input  wire           i_clk,
    input  wire           i_rst_n,
    input  wire           i_enable,
    input  wire           i_cfg_valid,  // One-cycle write strobe
    input  wire cfg_req_t i_cfg,
    output coeff_wr_t     o_wr,
    output cfg_err_t      o_err
);

    logic [7:0] fir_off;
    logic [7:0] hb_off;
    logic       fir_hit;
    logic       hb_hit;
    logic       addr_ok;
    logic       data_fits;
    logic       accept;

    logic       wr_en_q;
    cfg_err_t   err_q;
    bank_sel_e  bank_q;
    logic [4:0] tap_q;
    coeff_t     value_q;

    // ==================================================
    // Address and data classification
    // ==================================================

    assign accept = i_enable & i_cfg_valid;  // Disabled writes vanish silently

    // Offset from each base; an address below the base wraps and fails the compare
    assign fir_off = i_cfg.addr - `DECIM_FIR_BASE;
    assign hb_off  = i_cfg.addr - `DECIM_HB_BASE;

    assign fir_hit = (fir_off < 8'(`DECIM_FIR_TAPS));
    assign hb_hit  = (hb_off < 8'(`DECIM_HB_TAPS));
    assign addr_ok = fir_hit | hb_hit;

    assign data_fits = (i_cfg.data[31:`DECIM_COEFF_W] == '0);

    // ==================================================
    // Registered write and error strobes
    // ==================================================

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_en_q <= 1'b0;
            err_q   <= '0;
        end else begin
            wr_en_q         <= accept & addr_ok & data_fits;
            err_q.addr_err  <= accept & ~addr_ok;             // Wins over range
            err_q.range_err <= accept & addr_ok & ~data_fits;
        end
    end

    // Payload only matters while wr_en_q is high
    always_ff @(posedge i_clk) begin
        if (accept) begin
            bank_q  <= fir_hit ? bank_fir : bank_hb;
            tap_q   <= fir_hit ? fir_off[4:0] : hb_off[4:0];
            value_q <= i_cfg.data[`DECIM_COEFF_W-1:0];
        end
    end

    assign o_wr = '{en: wr_en_q, bank: bank_q, tap: tap_q, value: value_q};
    assign o_err = err_q;

endmodule

`default_nettype wire

//--- hdl/coeff_bank.sv
`default_nettype none

`include "decim_regs_defs.svh"

module coeff_bank
    import decim_regs_pkg::*;
(
    input  wire                              i_clk,
    input  wire                              i_rst_n,
    input  wire coeff_wr_t                   i_wr,
    output coeff_t [`DECIM_FIR_TAPS-1:0]     o_fir_coeff,
    output coeff_t [`DECIM_HB_TAPS-1:0]      o_hb_coeff
);

    logic fir_wr;
    logic hb_wr;

    // Default tap value of a pass-through filter
    function automatic coeff_t pass_tap(input int idx, input int center);
        coeff_t value;
        if (idx == center) begin
            value = `DECIM_UNITY;
        end else begin
            value = '0;
        end
        return value;
    endfunction

    assign fir_wr = i_wr.en && (i_wr.bank == bank_fir);
    assign hb_wr  = i_wr.en && (i_wr.bank == bank_hb);

    // ==================================================
    // FIR bank
    // ==================================================

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < `DECIM_FIR_TAPS; i++) begin
                o_fir_coeff[i] <= pass_tap(i, `DECIM_FIR_CENTER);
            end
        end else if (fir_wr) begin
            for (int i = 0; i < `DECIM_FIR_TAPS; i++) begin
                if (i_wr.tap == 5'(i)) begin
                    o_fir_coeff[i] <= i_wr.value;
                end
            end
        end
    end

    // ==================================================
    // Halfband bank
    // ==================================================

    // Tap index is already range checked by the decoder
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < `DECIM_HB_TAPS; i++) begin
                o_hb_coeff[i] <= pass_tap(i, `DECIM_HB_CENTER);
            end
        end else if (hb_wr) begin
            for (int i = 0; i < `DECIM_HB_TAPS; i++) begin
                if (i_wr.tap == 5'(i)) begin
                    o_hb_coeff[i] <= i_wr.value;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/status_reporter.sv
`default_nettype none

module status_reporter
    import decim_regs_pkg::*;
(
    input  wire               i_clk,
    input  wire               i_rst_n,
    input  wire               i_enable,
    input  wire stage_flags_t i_stage_valid,
    input  wire stage_flags_t i_stage_ovf,
    input  wire stage_flags_t i_stage_unf,
    input  wire cfg_err_t     i_cfg_err,      // From the write decoder
    output status_t           o_status,
    output logic              o_busy,
    output logic              o_error,
    output err_type_e         o_err_type
);

    logic      ovf_any;
    logic      unf_any;
    logic      err_any;
    logic      busy_d;
    status_t   status_d;
    err_type_e err_type_d;

    // ==================================================
    // Flag collection
    // ==================================================

    assign ovf_any = i_stage_ovf.cic | i_stage_ovf.fir | i_stage_ovf.hb;
    assign unf_any = i_stage_unf.cic | i_stage_unf.fir | i_stage_unf.hb;

    // Error bit comes from this cycle's flags, not last cycle's
    assign err_any = ovf_any | unf_any | i_cfg_err.addr_err | i_cfg_err.range_err;

    assign busy_d = i_stage_valid.cic | i_stage_valid.fir | i_stage_valid.hb;

    always_comb begin
        status_d.cic_active  = i_stage_valid.cic;
        status_d.fir_active  = i_stage_valid.fir;
        status_d.hb_active   = i_stage_valid.hb;
        status_d.error       = err_any;
        status_d.overflow    = ovf_any;
        status_d.underflow   = unf_any;
        status_d.addr_error  = i_cfg_err.addr_err;
        status_d.range_error = i_cfg_err.range_err;
    end

    // Stage faults outrank configuration faults
    always_comb begin
        if (ovf_any) begin
            err_type_d = err_overflow;
        end else if (unf_any) begin
            err_type_d = err_underflow;
        end else if (i_cfg_err.addr_err) begin
            err_type_d = err_invalid_addr;
        end else if (i_cfg_err.range_err) begin
            err_type_d = err_coeff_range;
        end else begin
            err_type_d = err_none;
        end
    end

    // ==================================================
    // Output registers
    // ==================================================

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_status   <= '0;
            o_busy     <= 1'b0;
            o_error    <= 1'b0;
            o_err_type <= err_none;
        end else if (!i_enable) begin
            // Disabled chain reports nothing
            o_status   <= '0;
            o_busy     <= 1'b0;
            o_error    <= 1'b0;
            o_err_type <= err_none;
        end else begin
            o_status   <= status_d;
            o_busy     <= busy_d;
            o_error    <= err_any;
            o_err_type <= err_type_d;
        end
    end

endmodule

`default_nettype wire

//--- hdl/decim_cfg_status_top.sv
`default_nettype none

`include "decim_regs_defs.svh"

module decim_cfg_status_top
    import decim_regs_pkg::*;
(
    input  wire                          i_clk,
    input  wire                          i_rst_n,
    input  wire                          i_enable,

    // Configuration write port
    input  wire                          i_cfg_valid,
    input  wire cfg_req_t                i_cfg,

    // Per-stage flags from the filter chain
    input  wire stage_flags_t            i_stage_valid,
    input  wire stage_flags_t            i_stage_ovf,
    input  wire stage_flags_t            i_stage_unf,

    output coeff_t [`DECIM_FIR_TAPS-1:0] o_fir_coeff,
    output coeff_t [`DECIM_HB_TAPS-1:0]  o_hb_coeff,

    output status_t                      o_status,
    output logic                         o_busy,
    output logic                         o_error,
    output err_type_e                    o_err_type
);

    wire coeff_wr_t cfg_wr;    // Decoded coefficient write
    wire cfg_err_t  cfg_err;   // Rejected write reasons

    // ==================================================
    // Write decode, bank storage, status
    // ==================================================

    cfg_write_decoder i_cfg_write_decoder (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_enable    (i_enable),
        .i_cfg_valid (i_cfg_valid),
        .i_cfg       (i_cfg),
        .o_wr        (cfg_wr),
        .o_err       (cfg_err)
    );

    coeff_bank i_coeff_bank (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_wr        (cfg_wr),
        .o_fir_coeff (o_fir_coeff),
        .o_hb_coeff  (o_hb_coeff)
    );

    status_reporter i_status_reporter (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_enable      (i_enable),
        .i_stage_valid (i_stage_valid),
        .i_stage_ovf   (i_stage_ovf),
        .i_stage_unf   (i_stage_unf),
        .i_cfg_err     (cfg_err),
        .o_status      (o_status),
        .o_busy        (o_busy),
        .o_error       (o_error),
        .o_err_type    (o_err_type)
    );

endmodule

`default_nettype wire

//--- test/decim_cfg_status_sva.sv
`default_nettype none

module decim_cfg_status_sva
    import decim_regs_pkg::*;
(
    input wire          i_clk,
    input wire          i_rst_n,
    input wire          i_enable,
    input wire status_t i_status,
    input wire          i_busy,
    input wire          i_error
);
    timeunit 1ns;
    timeprecision 1ps;

    // ==================================================
    // Status consistency
    // ==================================================

    // Bits 3..0 are overflow, underflow, addr and range
    error_matches_bits: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_error == (|i_status[3:0])
    ) else $error("error flag disagrees with status bits 3 to 0");

    busy_needs_active: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_busy |-> (|i_status[7:5])
    ) else $error("busy is set with no stage active");

    // Disabled chain reports nothing
    disable_clears: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        !i_enable |=> (i_status == '0)
    ) else $error("status not cleared after enable went low");

endmodule

bind decim_cfg_status_top decim_cfg_status_sva i_decim_cfg_status_sva (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_enable (i_enable),
    .i_status (o_status),
    .i_busy   (o_busy),
    .i_error  (o_error)
);

`default_nettype wire

//--- test/tb_decim_cfg_status.sv
`default_nettype none

`include "decim_regs_defs.svh"

module tb_decim_cfg_status
    import decim_regs_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_period   = 40;
    localparam int reset_cycles = 16;
    localparam stage_flags_t no_flags = 3'b000;

    typedef struct packed {
        logic         chk;      // Row comes from the table
        logic         en;
        logic         wr;
        logic [7:0]   addr;
        logic [31:0]  data;
        stage_flags_t vld;
        stage_flags_t ovf;
        stage_flags_t unf;
        logic         gap;      // Two idle cycles follow
        err_type_e    exp_err;  // Error type right after the row is sampled
    } row_t;

    logic                         i_clk = 1'b0;
    logic                         i_rst_n;
    logic                         i_enable;
    logic                         i_cfg_valid;
    cfg_req_t                     i_cfg;
    stage_flags_t                 i_stage_valid;
    stage_flags_t                 i_stage_ovf;
    stage_flags_t                 i_stage_unf;
    coeff_t [`DECIM_FIR_TAPS-1:0] o_fir_coeff;
    coeff_t [`DECIM_HB_TAPS-1:0]  o_hb_coeff;
    status_t                      o_status;
    logic                         o_busy;
    logic                         o_error;
    err_type_e                    o_err_type;

    row_t      rows[$];
    row_t      applied;     // Inputs the DUT samples on the coming edge

    // Reference model state
    coeff_t    exp_fir [`DECIM_FIR_TAPS];
    coeff_t    exp_hb [`DECIM_HB_TAPS];
    status_t   exp_status;
    logic      exp_busy;
    logic      exp_error;
    err_type_e exp_type;
    cfg_err_t  pend_err;    // Write error decoded on the last edge
    logic      pend_en;
    logic      pend_hb;
    int        pend_tap;
    coeff_t    pend_val;

    decim_cfg_status_top i_decim_cfg_status_top (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_enable      (i_enable),
        .i_cfg_valid   (i_cfg_valid),
        .i_cfg         (i_cfg),
        .i_stage_valid (i_stage_valid),
        .i_stage_ovf   (i_stage_ovf),
        .i_stage_unf   (i_stage_unf),
        .o_fir_coeff   (o_fir_coeff),
        .o_hb_coeff    (o_hb_coeff),
        .o_status      (o_status),
        .o_busy        (o_busy),
        .o_error       (o_error),
        .o_err_type    (o_err_type)
    );

    always #(clk_period / 2) i_clk = ~i_clk;

    // ==================================================
    // Table helpers
    // ==================================================

    function automatic row_t mk(input int en, input int wr, input int addr,
                                input logic [31:0] data, input stage_flags_t vld,
                                input stage_flags_t ovf, input stage_flags_t unf,
                                input int gap, input err_type_e exp_err);
        row_t r;
        r.chk     = 1'b1;
        r.en      = (en != 0);
        r.wr      = (wr != 0);
        r.addr    = 8'(addr);
        r.data    = data;
        r.vld     = vld;
        r.ovf     = ovf;
        r.unf     = unf;
        r.gap     = (gap != 0);
        r.exp_err = exp_err;
        return r;
    endfunction

    // Quiet cycle that keeps the enable level
    function automatic row_t idle_of(input row_t r);
        row_t q;
        q    = '0;
        q.en = r.en;
        return q;
    endfunction

    function automatic logic [31:0] rnd18();
        return $urandom & 32'h0003_FFFF;
    endfunction

    // ==================================================
    // Reference model
    // ==================================================

    task automatic reset_model();
        for (int i = 0; i < `DECIM_FIR_TAPS; i++) begin
            exp_fir[i] = (i == `DECIM_FIR_CENTER) ? `DECIM_UNITY : '0;
        end
        for (int i = 0; i < `DECIM_HB_TAPS; i++) begin
            exp_hb[i] = (i == `DECIM_HB_CENTER) ? `DECIM_UNITY : '0;
        end
        pend_err = '0;
        pend_en  = 1'b0;
    endtask

    // One clock edge: commit the older write, then take the sampled row
    task automatic advance_model(input row_t p);
        logic ovf;
        logic unf;
        int   off_fir;
        int   off_hb;
        logic in_fir;
        logic in_hb;
        if (pend_en && pend_hb) begin
            exp_hb[pend_tap] = pend_val;
        end else if (pend_en) begin
            exp_fir[pend_tap] = pend_val;
        end
        ovf = |p.ovf;
        unf = |p.unf;
        exp_status = '0;
        exp_type   = err_none;
        if (p.en) begin
            exp_status.cic_active  = p.vld.cic;
            exp_status.fir_active  = p.vld.fir;
            exp_status.hb_active   = p.vld.hb;
            exp_status.overflow    = ovf;
            exp_status.underflow   = unf;
            exp_status.addr_error  = pend_err.addr_err;
            exp_status.range_error = pend_err.range_err;
            exp_status.error       = ovf | unf | pend_err.addr_err | pend_err.range_err;
            if (ovf) begin
                exp_type = err_overflow;
            end else if (unf) begin
                exp_type = err_underflow;
            end else if (pend_err.addr_err) begin
                exp_type = err_invalid_addr;
            end else if (pend_err.range_err) begin
                exp_type = err_coeff_range;
            end
        end
        exp_busy  = |exp_status[7:5];
        exp_error = exp_status.error;
        off_fir   = int'(p.addr) - int'(`DECIM_FIR_BASE);
        off_hb    = int'(p.addr) - int'(`DECIM_HB_BASE);
        in_fir    = (off_fir >= 0) && (off_fir < `DECIM_FIR_TAPS);
        in_hb     = (off_hb >= 0) && (off_hb < `DECIM_HB_TAPS);
        pend_err  = '0;
        pend_en   = 1'b0;
        if (p.en && p.wr) begin
            if (!in_fir && !in_hb) begin
                pend_err.addr_err = 1'b1;
            end else if (p.data > 32'h0003_FFFF) begin
                pend_err.range_err = 1'b1;
            end else begin
                pend_en  = 1'b1;
                pend_hb  = in_hb;
                pend_tap = in_hb ? off_hb : off_fir;
                pend_val = p.data[`DECIM_COEFF_W-1:0];
            end
        end
    endtask

    // ==================================================
    // Compare tasks
    // ==================================================

    task automatic stop_on_mismatch(input string msg);
        $display("MISMATCH at %0t ns: %s", $time, msg);
        $display("tests failed");
        $fatal(1, "first mismatch ends the run");
    endtask

    task automatic check_coeffs(input coeff_t [`DECIM_FIR_TAPS-1:0] got_fir,
                                input coeff_t [`DECIM_HB_TAPS-1:0] got_hb);
        for (int i = 0; i < `DECIM_FIR_TAPS; i++) begin
            if (got_fir[i] !== exp_fir[i]) begin
                stop_on_mismatch($sformatf("FIR tap %0d is %h, expected %h",
                                           i, got_fir[i], exp_fir[i]));
            end
        end
        for (int i = 0; i < `DECIM_HB_TAPS; i++) begin
            if (got_hb[i] !== exp_hb[i]) begin
                stop_on_mismatch($sformatf("halfband tap %0d is %h, expected %h",
                                           i, got_hb[i], exp_hb[i]));
            end
        end
    endtask

    task automatic check_status(input status_t got, input status_t exp,
                                input logic got_busy, input logic exp_bsy,
                                input logic got_err, input logic exp_err);
        if (got !== exp || got_busy !== exp_bsy || got_err !== exp_err) begin
            stop_on_mismatch($sformatf("status %b busy %b error %b, expected %b %b %b",
                                       got, got_busy, got_err, exp, exp_bsy, exp_err));
        end
    endtask

    task automatic check_err(input err_type_e got, input err_type_e exp, input string what);
        if (got !== exp) begin
            stop_on_mismatch($sformatf("error type %0d, expected %0d (%s)", got, exp, what));
        end
    endtask

    // Drive on a rising edge and check what the DUT made of the previous row
    task automatic step(input row_t r);
        row_t sampled;
        @(posedge i_clk);
        sampled = applied;
        advance_model(sampled);
        applied = r;
        i_enable      <= r.en;
        i_cfg_valid   <= r.wr;
        i_cfg         <= '{addr: r.addr, data: r.data};
        i_stage_valid <= r.vld;
        i_stage_ovf   <= r.ovf;
        i_stage_unf   <= r.unf;
        @(negedge i_clk);
        check_status(o_status, exp_status, o_busy, exp_busy, o_error, exp_error);
        check_err(o_err_type, exp_type, "model");
        if (sampled.chk) begin
            check_err(o_err_type, sampled.exp_err, "table");
        end
        check_coeffs(o_fir_coeff, o_hb_coeff);
    endtask

    // ==================================================
    // Stimulus
    // ==================================================

    initial begin
        i_rst_n       = 1'b0;
        i_enable      = 1'b1;
        i_cfg_valid   = 1'b0;
        i_cfg         = '0;
        i_stage_valid = '0;
        i_stage_ovf   = '0;
        i_stage_unf   = '0;
        void'($urandom(32'hf1f0aac8));
        applied = '0;
        applied.en = 1'b1;
        reset_model();

        // en wr addr data vld ovf unf gap exp_err
        rows.push_back(mk(1, 1,   3, 32'h1_2345,   no_flags, no_flags, no_flags, 1, err_none));
        rows.push_back(mk(1, 1,   8, rnd18(),      no_flags, no_flags, no_flags, 1, err_none));
        rows.push_back(mk(1, 1,  64, rnd18(),      no_flags, no_flags, no_flags, 1, err_none));
        rows.push_back(mk(1, 1,  72, 32'h3_FFFF,   no_flags, no_flags, no_flags, 1, err_none));
        rows.push_back(mk(1, 1,  15, rnd18(),      no_flags, no_flags, no_flags, 0, err_none));
        rows.push_back(mk(1, 1,  68, rnd18(),      no_flags, no_flags, no_flags, 0, err_none));
        rows.push_back(mk(1, 1,   0, rnd18(),      no_flags, no_flags, no_flags, 0, err_none));
        rows.push_back(mk(1, 1,   0, rnd18(),      no_flags, no_flags, no_flags, 1, err_none));
        rows.push_back(mk(1, 1,  16, 32'h5,        no_flags, no_flags, no_flags, 1, err_none));
        rows.push_back(mk(1, 1,  63, 32'h5,        no_flags, no_flags, no_flags, 1, err_none));
        rows.push_back(mk(1, 1,  73, 32'h5,        no_flags, no_flags, no_flags, 1, err_none));
        rows.push_back(mk(1, 1, 255, 32'h5,        no_flags, no_flags, no_flags, 1, err_none));
        rows.push_back(mk(1, 1,   2, 32'h4_0000,   no_flags, no_flags, no_flags, 1, err_none));
        rows.push_back(mk(1, 1,  70, 32'hFFFF_FFFF, no_flags, no_flags, no_flags, 1, err_none));
        rows.push_back(mk(1, 1,  99, 32'h8000_0000, no_flags, no_flags, no_flags, 1, err_none));
        rows.push_back(mk(1, 0,   0, 0, no_flags, 3'b010, no_flags, 1, err_overflow));
        rows.push_back(mk(1, 0,   0, 0, no_flags, no_flags, 3'b100, 1, err_underflow));
        rows.push_back(mk(1, 0,   0, 0, no_flags, 3'b001, 3'b010, 1, err_overflow));
        // Write errors meeting stage flags in the same reporter cycle
        rows.push_back(mk(1, 1,  20, 32'h1,        no_flags, no_flags, no_flags, 0, err_none));
        rows.push_back(mk(1, 0,   0, 0,            no_flags, 3'b001, no_flags, 1, err_overflow));
        rows.push_back(mk(1, 1,   5, 32'h4_0000,   no_flags, no_flags, no_flags, 0, err_none));
        rows.push_back(mk(1, 0,   0, 0,            no_flags, no_flags, 3'b010, 1, err_underflow));
        rows.push_back(mk(1, 1,  30, 32'h1,        no_flags, no_flags, no_flags, 0, err_none));
        rows.push_back(mk(1, 0,   0, 0,            no_flags, no_flags, no_flags, 1, err_invalid_addr));
        rows.push_back(mk(1, 1,  66, 32'h4_0001,   no_flags, no_flags, no_flags, 0, err_none));
        rows.push_back(mk(1, 0,   0, 0,            no_flags, no_flags, no_flags, 1, err_coeff_range));
        rows.push_back(mk(1, 1,  40, 32'h1,        no_flags, no_flags, no_flags, 0, err_none));
        rows.push_back(mk(1, 1,   3, 32'h4_0000,   no_flags, no_flags, no_flags, 0, err_invalid_addr));
        rows.push_back(mk(1, 0,   0, 0,            no_flags, no_flags, no_flags, 1, err_coeff_range));
        rows.push_back(mk(1, 0,   0, 0,            3'b111,   no_flags, no_flags, 1, err_none));
        rows.push_back(mk(1, 0,   0, 0,            3'b010,   no_flags, no_flags, 1, err_none));
        // Disabled chain
        rows.push_back(mk(0, 1,   1, 32'h777,      3'b111,   3'b111,   3'b111,   1, err_none));
        rows.push_back(mk(0, 1, 200, 32'h1,        no_flags, no_flags, no_flags, 0, err_none));
        rows.push_back(mk(1, 1, 100, 32'h1,        no_flags, no_flags, no_flags, 0, err_none));
        rows.push_back(mk(0, 0,   0, 0,            no_flags, no_flags, no_flags, 0, err_none));
        rows.push_back(mk(1, 1,   6, rnd18(),      no_flags, no_flags, no_flags, 0, err_none));
        rows.push_back(mk(0, 0,   0, 0,            3'b100,   no_flags, no_flags, 1, err_none));
        rows.push_back(mk(1, 1,   1, 32'h2222,     3'b001,   no_flags, no_flags, 1, err_none));

        repeat (reset_cycles) @(posedge i_clk);
        i_rst_n <= 1'b1;
        step(applied);      // Defaults and quiet status after reset
        step(applied);
        foreach (rows[k]) begin
            step(rows[k]);
            if (rows[k].gap) begin
                step(idle_of(rows[k]));
                step(idle_of(rows[k]));
            end
        end
        step(applied);
        $display("all tests passed");
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        #1;
        #((rows.size() * 4 + reset_cycles + 24) * clk_period);
        $display("Timeout: the table did not finish in the expected time");
        $display("tests failed");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+include
hdl/decim_regs_pkg.sv
hdl/cfg_write_decoder.sv
hdl/coeff_bank.sv
hdl/status_reporter.sv
hdl/decim_cfg_status_top.sv
test/decim_cfg_status_sva.sv
test/tb_decim_cfg_status.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       ?= tb_decim_cfg_status
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf $(OBJ_DIR)
